//--- c4_pkg.sv
// connect four shared definitions
package c4_pkg;

   // board
   localparam int N_COLS  = 7;
   localparam int N_ROWS  = 6;
   localparam int N_CELLS = N_COLS * N_ROWS;   // index is row*N_COLS + col, row 0 at bottom
   localparam int WIN_LEN = 4;

   // 1280x1024 at 60 Hz, 108 MHz pixel clock
   localparam int H_ACTIVE     = 1280;
   localparam int H_SYNC_START = 1328;
   localparam int H_SYNC_END   = 1440;
   localparam int H_TOTAL      = 1688;
   localparam int V_ACTIVE     = 1024;
   localparam int V_SYNC_START = 1025;
   localparam int V_SYNC_END   = 1028;
   localparam int V_TOTAL      = 1066;

   // grid placement on screen
   localparam int BOARD_X0 = 10;
   localparam int BOARD_Y0 = 40;
   localparam int PITCH    = 110;   // bar plus cell
   localparam int BAR      = 30;
   localparam int CELL     = PITCH - BAR;
   localparam int BOARD_W  = N_COLS * PITCH + BAR;   // closing bar on the right
   localparam int BOARD_H  = N_ROWS * PITCH + BAR;

   // result codes
   localparam logic [1:0] WIN_NONE = 2'd0;
   localparam logic [1:0] WIN_P1   = 2'd1;
   localparam logic [1:0] WIN_P2   = 2'd2;
   localparam logic [1:0] WIN_DRAW = 2'd3;

   typedef struct packed {
      logic [N_CELLS-1:0] occupied;
      logic [N_CELLS-1:0] owner;   // 1 = player 2
   } board_t;

   typedef struct packed {
      logic       turn;     // 1 = player 2 to move
      logic [1:0] winner;
      logic       over;
   } game_status_t;

   typedef struct packed {
      logic [10:0] h;
      logic [10:0] v;
      logic        active;
      logic        hsync;   // active low
      logic        vsync;   // active low
   } beam_t;

   typedef struct packed {
      logic [7:0] r;
      logic [7:0] g;
      logic [7:0] b;
   } rgb_t;

   typedef struct packed {
      rgb_t rgb;
      logic hsync;
      logic vsync;
      logic blank_n;
   } vga_out_t;

   typedef logic [N_COLS-1:0] col_sel_t;   // one-hot, bit 0 leftmost

   localparam rgb_t COLOR_GRID  = '{r: 8'd255, g: 8'd255, b: 8'd0};
   localparam rgb_t COLOR_P1    = '{r: 8'd255, g: 8'd0,   b: 8'd0};
   localparam rgb_t COLOR_P2    = '{r: 8'd0,   g: 8'd0,   b: 8'd255};
   localparam rgb_t COLOR_BG    = '{r: 8'd255, g: 8'd255, b: 8'd255};
   localparam rgb_t COLOR_BLACK = '{r: 8'd0,   g: 8'd0,   b: 8'd0};

endpackage

//--- c4_win_check.sv
// four in a row detector
`timescale 1ns/100ps
module c4_win_check
   import c4_pkg::*;
(
   input  board_t board,
   input  logic   player,
   output logic   four_found
);

   logic [N_CELLS-1:0] mine;

   // cells held by the player being checked
   assign mine = board.occupied & ~(board.owner ^ {N_CELLS{player}});

   always_comb
   begin
      logic run;

      four_found = 1'b0;

      // horizontal
      for (int r = 0; r < N_ROWS; r++)
         for (int c = 0; c + WIN_LEN <= N_COLS; c++)
         begin
            run = 1'b1;
            for (int k = 0; k < WIN_LEN; k++)
               run &= mine[r * N_COLS + c + k];
            four_found |= run;
         end

      // vertical
      for (int r = 0; r + WIN_LEN <= N_ROWS; r++)
         for (int c = 0; c < N_COLS; c++)
         begin
            run = 1'b1;
            for (int k = 0; k < WIN_LEN; k++)
               run &= mine[(r + k) * N_COLS + c];
            four_found |= run;
         end

      // rising, up and to the right
      for (int r = 0; r + WIN_LEN <= N_ROWS; r++)
         for (int c = 0; c + WIN_LEN <= N_COLS; c++)
         begin
            run = 1'b1;
            for (int k = 0; k < WIN_LEN; k++)
               run &= mine[(r + k) * N_COLS + c + k];
            four_found |= run;
         end

      // falling, down and to the right
      for (int r = WIN_LEN - 1; r < N_ROWS; r++)
         for (int c = 0; c + WIN_LEN <= N_COLS; c++)
         begin
            run = 1'b1;
            for (int k = 0; k < WIN_LEN; k++)
               run &= mine[(r - k) * N_COLS + c + k];
            four_found |= run;
         end
   end

endmodule

//--- c4_game.sv
// connect four game control
`timescale 1ns/100ps
module c4_game
   import c4_pkg::*;
(
   input  logic         CLK_108,
   input  logic         rst,
   input  col_sel_t     col_sel,
   input  logic         drop_p1,
   input  logic         drop_p2,
   output board_t       board,
   output game_status_t status
);

   typedef enum logic {S_PLAY, S_CHECK} seq_t;

   seq_t                   state;
   logic [N_COLS-1:0][2:0] height;   // pieces per column
   logic [2:0]             sel_col;
   logic [5:0]             land_idx;
   logic                   strobe_ok;
   logic                   col_ok;
   logic                   accept;
   logic                   four_found;

   always_comb
   begin
      sel_col = '0;
      for (int c = 0; c < N_COLS; c++)
         if (col_sel[c])
            sel_col = 3'(c);
   end

   // only the player whose turn it is may drop, and alone
   assign strobe_ok = status.turn ? (drop_p2 && !drop_p1) : (drop_p1 && !drop_p2);
   assign col_ok    = height[sel_col] < 3'(N_ROWS);
   assign accept    = strobe_ok && $onehot(col_sel) && col_ok && !status.over
                      && (state == S_PLAY);
   assign land_idx  = 6'(height[sel_col] * N_COLS + sel_col);   // lowest free row

   c4_win_check win_check_i (
      .board      (board),
      .player     (status.turn),   // turn still names the mover here
      .four_found (four_found)
   );

   always_ff @(posedge CLK_108 or posedge rst)
   begin
      if (rst)
      begin
         state  <= S_PLAY;
         height <= '0;
         board  <= '0;
         status <= '0;
      end
      else
      begin
         case (state)
            S_PLAY:
            begin
               if (accept)
               begin
                  board.occupied[land_idx] <= 1'b1;
                  board.owner[land_idx]    <= status.turn;
                  height[sel_col]          <= height[sel_col] + 3'd1;
                  state                    <= S_CHECK;
               end
            end

            S_CHECK:
            begin
               state <= S_PLAY;
               if (four_found)
               begin
                  status.winner <= status.turn ? WIN_P2 : WIN_P1;
                  status.over   <= 1'b1;
               end
               else if (&board.occupied)
               begin
                  status.winner <= WIN_DRAW;   // board full, nobody won
                  status.over   <= 1'b1;
               end
               else
                  status.turn <= ~status.turn;
            end

            default:
               state <= S_PLAY;
         endcase
      end
   end

endmodule

//--- vga_timing.sv
// vga beam counters
`timescale 1ns/100ps
module vga_timing
   import c4_pkg::*;
(
   input  logic  CLK_108,
   input  logic  rst,
   output beam_t beam
);

   logic [10:0] h_nxt;
   logic [10:0] v_nxt;

   always_comb
   begin
      h_nxt = beam.h + 11'd1;
      v_nxt = beam.v;
      if (beam.h == 11'(H_TOTAL - 1))
      begin
         h_nxt = '0;
         if (beam.v == 11'(V_TOTAL - 1))
            v_nxt = '0;
         else
            v_nxt = beam.v + 11'd1;
      end
   end

   // flags come from the next position so they line up with h and v
   always_ff @(posedge CLK_108 or posedge rst)
   begin
      if (rst)
      begin
         beam.h      <= '0;
         beam.v      <= '0;
         beam.active <= 1'b1;   // pixel 0 is visible
         beam.hsync  <= 1'b1;
         beam.vsync  <= 1'b1;
      end
      else
      begin
         beam.h      <= h_nxt;
         beam.v      <= v_nxt;
         beam.active <= (h_nxt < H_ACTIVE) && (v_nxt < V_ACTIVE);
         beam.hsync  <= !((h_nxt >= H_SYNC_START) && (h_nxt < H_SYNC_END));
         beam.vsync  <= !((v_nxt >= V_SYNC_START) && (v_nxt < V_SYNC_END));
      end
   end

endmodule

//--- c4_render.sv
// board pixel renderer
`timescale 1ns/100ps
module c4_render
   import c4_pkg::*;
(
   input  logic     CLK_108,
   input  logic     rst,
   input  beam_t    beam,
   input  board_t   board,
   output vga_out_t vga
);

   logic       in_board;
   logic       hit_x;
   logic       hit_y;
   logic [2:0] col;
   logic [2:0] scr_row;   // 0 at top of screen
   logic [2:0] brd_row;
   logic [5:0] cell_idx;
   rgb_t       pix;

   always_comb
   begin
      in_board = (beam.h >= BOARD_X0) && (beam.h < BOARD_X0 + BOARD_W)
                 && (beam.v >= BOARD_Y0) && (beam.v < BOARD_Y0 + BOARD_H);

      // inside a cell opening, anything else on the board is bar
      hit_x = 1'b0;
      col   = '0;
      for (int c = 0; c < N_COLS; c++)
         if ((beam.h >= BOARD_X0 + c * PITCH + BAR) && (beam.h < BOARD_X0 + (c + 1) * PITCH))
         begin
            hit_x = 1'b1;
            col   = 3'(c);
         end

      hit_y   = 1'b0;
      scr_row = '0;
      for (int r = 0; r < N_ROWS; r++)
         if ((beam.v >= BOARD_Y0 + r * PITCH + BAR) && (beam.v < BOARD_Y0 + (r + 1) * PITCH))
         begin
            hit_y   = 1'b1;
            scr_row = 3'(r);
         end

      brd_row  = 3'(N_ROWS - 1) - scr_row;   // bottom row is row 0
      cell_idx = 6'(brd_row * N_COLS + col);

      if (!beam.active)
         pix = COLOR_BLACK;
      else if (!in_board)
         pix = COLOR_BG;
      else if (!(hit_x && hit_y))
         pix = COLOR_GRID;
      else if (!board.occupied[cell_idx])
         pix = COLOR_BG;   // empty hole
      else if (board.owner[cell_idx])
         pix = COLOR_P2;
      else
         pix = COLOR_P1;
   end

   always_ff @(posedge CLK_108 or posedge rst)
   begin
      if (rst)
      begin
         vga.rgb     <= '0;
         vga.hsync   <= 1'b1;
         vga.vsync   <= 1'b1;
         vga.blank_n <= 1'b0;
      end
      else
      begin
         vga.rgb     <= pix;
         vga.hsync   <= beam.hsync;
         vga.vsync   <= beam.vsync;
         vga.blank_n <= beam.active;
      end
   end

endmodule

//--- connect_4.sv
// connect four top level
`timescale 1ns/100ps
module connect_4
   import c4_pkg::*;
(
   input  logic         CLK_108,
   input  logic         rst,
   input  col_sel_t     col_sel,
   input  logic         drop_p1,
   input  logic         drop_p2,
   output board_t       board,
   output game_status_t status,
   output vga_out_t     vga
);

   beam_t beam;

   c4_game game_i (
      .CLK_108 (CLK_108),
      .rst     (rst),
      .col_sel (col_sel),
      .drop_p1 (drop_p1),
      .drop_p2 (drop_p2),
      .board   (board),
      .status  (status)
   );

   vga_timing timing_i (
      .CLK_108 (CLK_108),
      .rst     (rst),
      .beam    (beam)
   );

   c4_render render_i (
      .CLK_108 (CLK_108),
      .rst     (rst),
      .beam    (beam),
      .board   (board),
      .vga     (vga)
   );

endmodule

//--- connect_4_chk.sv
// game control assertions
`timescale 1ns/100ps
module connect_4_chk
   import c4_pkg::*;
(
   input logic         CLK_108,
   input logic         rst,
   input board_t       board,
   input game_status_t status
);

   int fail_cnt = 0;   // failed assertions so far

   // finished game is frozen
   a_frozen: assert property (@(posedge CLK_108) disable iff (rst)
      $past(status.over) |-> (board == $past(board)) && (status == $past(status)))
      else
      begin
         $error("board or status moved after the game was over");
         fail_cnt++;
      end

   a_turn_hold: assert property (@(posedge CLK_108) disable iff (rst)
      status.over |-> $stable(status.turn))
      else
      begin
         $error("turn flipped while the game was over");
         fail_cnt++;
      end

   a_one_cell: assert property (@(posedge CLK_108) disable iff (rst)
      $countones(board.occupied ^ $past(board.occupied)) <= 1)
      else
      begin
         $error("more than one cell filled in one cycle");
         fail_cnt++;
      end

   a_owner_cell: assert property (@(posedge CLK_108) disable iff (rst)
      $countones(board.owner ^ $past(board.owner)) <= 1)
      else
      begin
         $error("more than one owner bit changed in one cycle");
         fail_cnt++;
      end

endmodule

bind c4_game connect_4_chk chk_i (
   .CLK_108 (CLK_108),
   .rst     (rst),
   .board   (board),
   .status  (status)
);

//--- tb_connect_4.sv
// connect four testbench
`timescale 1ns/100ps
module tb_connect_4
   import c4_pkg::*;
();

   localparam int FRAME = H_TOTAL * V_TOTAL;

   logic         CLK_108;
   logic         rst;
   col_sel_t     col_sel;
   logic         drop_p1;
   logic         drop_p2;
   board_t       board;
   game_status_t status;
   vga_out_t     vga;

   int     v_player[$];
   int     v_col[$];
   int     v_row[$];
   int     v_win[$];
   int     n_vec = 0;
   int     edge_cnt;          // edges since reset release
   bit     frame_done = 1'b0;
   board_t mdl;               // reference board
   int     mdl_h[N_COLS];
   logic   mdl_turn;

   connect_4 connect_4_i (
      .CLK_108 (CLK_108),
      .rst     (rst),
      .col_sel (col_sel),
      .drop_p1 (drop_p1),
      .drop_p2 (drop_p2),
      .board   (board),
      .status  (status),
      .vga     (vga)
   );

   always #4 CLK_108 = ~CLK_108;

   always @(posedge CLK_108 or posedge rst)
   begin
      if (rst)
         edge_cnt <= 0;
      else
         edge_cnt <= edge_cnt + 1;
   end

   task automatic report_fail(input string msg);
      $display("%s", msg);
      $display("CHECKS FAILED");
      $fatal(1, "stopping");
   endtask

   // screen colour from the grid geometry and the model board
   function automatic rgb_t expected_colour(input int h, input int v);
      int x;
      int y;
      int c;
      int r;
      int idx;
      x = h - BOARD_X0;
      y = v - BOARD_Y0;
      if (h >= H_ACTIVE || v >= V_ACTIVE)
         return COLOR_BLACK;
      if (x < 0 || y < 0 || x >= N_COLS * PITCH + BAR || y >= N_ROWS * PITCH + BAR)
         return COLOR_BG;
      c = x / PITCH;
      r = y / PITCH;
      if ((x % PITCH) < BAR || (y % PITCH) < BAR || c >= N_COLS || r >= N_ROWS)
         return COLOR_GRID;
      idx = (N_ROWS - 1 - r) * N_COLS + c;   // screen row 0 is the top board row
      if (!mdl.occupied[idx])
         return COLOR_BG;
      return mdl.owner[idx] ? COLOR_P2 : COLOR_P1;
   endfunction

   function automatic int cell_pixel(input int row, input int col);
      int h;
      int v;
      h = BOARD_X0 + col * PITCH + BAR + CELL / 2;
      v = BOARD_Y0 + (N_ROWS - 1 - row) * PITCH + BAR + CELL / 2;
      return v * H_TOTAL + h;
   endfunction

   task automatic apply_reset();
      rst     = 1'b1;
      col_sel = '0;
      drop_p1 = 1'b0;
      drop_p2 = 1'b0;
      repeat (2) @(posedge CLK_108);
      #1;
      assert (board == '0 && status == '0)
         else report_fail($sformatf("Error %0t: game not cleared by reset", $time));
      assert (vga.hsync && vga.vsync && vga.rgb == '0)
         else report_fail($sformatf("Error %0t: vga outputs wrong in reset", $time));
      rst      = 1'b0;
      mdl      = '0;
      mdl_turn = 1'b0;
      foreach (mdl_h[c])
         mdl_h[c] = 0;
   endtask

   task automatic do_move(input int i);
      board_t       old_board;
      game_status_t old_status;
      game_status_t exp_st;
      int           idx;
      old_board  = board;
      old_status = status;
      @(posedge CLK_108);
      #1;
      col_sel = col_sel_t'(1 << v_col[i]);
      drop_p1 = (v_player[i] == 1);
      drop_p2 = (v_player[i] == 2);
      @(posedge CLK_108);   // edge N takes the drop
      #1;
      col_sel = '0;
      drop_p1 = 1'b0;
      drop_p2 = 1'b0;
      @(posedge CLK_108);   // check cycle
      #1;
      if (v_row[i] == 7)
      begin
         assert (board == old_board && status == old_status)
            else report_fail($sformatf("Error %0t: vector %0d ignored drop changed the game",
                                       $time, i));
      end
      else
      begin
         assert (mdl_h[v_col[i]] == v_row[i])
            else report_fail($sformatf("Error %0t: vector %0d row %0d, model says %0d",
                                       $time, i, v_row[i], mdl_h[v_col[i]]));
         idx = v_row[i] * N_COLS + v_col[i];
         mdl.occupied[idx] = 1'b1;
         mdl.owner[idx]    = (v_player[i] == 2);
         mdl_h[v_col[i]]++;
         if (v_win[i] == 0)
            mdl_turn = ~mdl_turn;
         exp_st.turn   = mdl_turn;
         exp_st.winner = 2'(v_win[i]);
         exp_st.over   = (v_win[i] != 0);
         assert (board == mdl)
            else report_fail($sformatf("Error %0t: vector %0d board mismatch", $time, i));
         assert (status == exp_st)
            else report_fail($sformatf("Error %0t: vector %0d status %b, expected %b",
                                       $time, i, status, exp_st));
      end
   endtask

   task automatic wait_pixel(input int idx);
      assert (edge_cnt <= idx)
         else report_fail($sformatf("pixel %0d already passed before it could be checked", idx));
      while (edge_cnt < idx + 1)
      begin
         @(posedge CLK_108);
         #2;
      end
   endtask

   task automatic check_colours();
      int   pix_q[$];
      int   h;
      int   v;
      rgb_t exp_c;
      pix_q.push_back(cell_pixel(0, 0));   // red
      pix_q.push_back(cell_pixel(1, 0));   // blue
      pix_q.push_back(cell_pixel(5, 6));   // empty
      pix_q.push_back(45 * H_TOTAL + 15);    // grid bar
      pix_q.push_back(900 * H_TOTAL + 1000); // background
      pix_q.push_back(100 * H_TOTAL + 1300); // blanked
      pix_q.sort();
      foreach (pix_q[k])
      begin
         wait_pixel(pix_q[k]);
         h = pix_q[k] % H_TOTAL;
         v = pix_q[k] / H_TOTAL;
         exp_c = expected_colour(h, v);
         assert (vga.rgb == exp_c)
            else report_fail($sformatf("Error %0t: pixel h %0d v %0d is %h, expected %h",
                                       $time, h, v, vga.rgb, exp_c));
      end
   endtask

   // sync and blanking per pixel over the first frame
   initial
   begin : frame_monitor
      int h;
      int v;
      @(negedge rst);
      for (int n = 1; n <= FRAME; n++)
      begin
         @(posedge CLK_108);
         #2;
         h = (n - 1) % H_TOTAL;
         v = (n - 1) / H_TOTAL;
         assert (vga.hsync == !(h >= H_SYNC_START && h < H_SYNC_END))
            else report_fail($sformatf("Error %0t: hsync wrong at h %0d v %0d", $time, h, v));
         assert (vga.vsync == !(v >= V_SYNC_START && v < V_SYNC_END))
            else report_fail($sformatf("Error %0t: vsync wrong at h %0d v %0d", $time, h, v));
         assert (vga.blank_n == (h < H_ACTIVE && v < V_ACTIVE))
            else report_fail($sformatf("Error %0t: blank_n wrong at h %0d v %0d", $time, h, v));
      end
      frame_done = 1'b1;
   end

   // assertions bound into the game control
   always @(connect_4_i.game_i.chk_i.fail_cnt)
   begin
      assert (connect_4_i.game_i.chk_i.fail_cnt == 0)
         else report_fail("a bound assertion on the game control failed");
   end

   initial
   begin : watchdog
      longint limit;
      wait (n_vec > 0);
      limit = (2 * longint'(FRAME) + 200 * n_vec) * 8;
      #(limit);
      report_fail("watchdog timeout, the run did not finish in time");
   end

   initial
   begin : main
      int    fd;
      int    p;
      int    c;
      int    r;
      int    w;
      int    sec;
      string hdr;
      CLK_108 = 1'b0;
      rst     = 1'b1;
      col_sel = '0;
      drop_p1 = 1'b0;
      drop_p2 = 1'b0;
      fd = $fopen("c4_vectors.txt", "r");
      if (fd == 0)
         report_fail("cannot open c4_vectors.txt");
      void'($fgets(hdr, fd));   // two header lines
      void'($fgets(hdr, fd));
      while ($fscanf(fd, "%d %d %d %d", p, c, r, w) == 4)
      begin
         v_player.push_back(p);
         v_col.push_back(c);
         v_row.push_back(r);
         v_win.push_back(w);
      end
      $fclose(fd);
      n_vec = v_player.size();
      sec   = 0;
      for (int i = 0; i < n_vec; i++)
      begin
         if (v_player[i] == 0)
         begin
            if (sec == 1)
            begin
               check_colours();
               wait (frame_done);
            end
            apply_reset();
            sec++;
         end
         else
            do_move(i);
      end
      wait (frame_done);
      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

//--- c4_vectors.txt
# each group of four numbers is one drop: player column landing_row expected_winner
# landing row 7 marks an ignored drop, player 0 resets and starts a new game
0 0 0 0
1 0 0 0   2 0 1 0   2 3 7 0   1 1 0 0
2 1 1 0   1 2 0 0   2 2 1 0   1 3 0 1
1 4 7 1
0 0 0 0
1 0 0 0   2 1 0 0   1 0 1 0   2 1 1 0
1 2 0 0   2 1 2 0   1 3 0 0   2 1 3 2
0 0 0 0
1 0 0 0   2 1 0 0   1 1 1 0   2 2 0 0
1 3 0 0   2 2 1 0   1 2 2 0   2 3 1 0
1 6 0 0   2 3 2 0   1 3 3 1
0 0 0 0
1 6 0 0   2 5 0 0   1 5 1 0   2 4 0 0
1 3 0 0   2 4 1 0   1 4 2 0   2 3 1 0
1 0 0 0   2 3 2 0   1 3 3 1
0 0 0 0
1 0 0 0   2 1 0 0   1 0 1 0   2 1 1 0   1 1 2 0   2 0 2 0
1 1 3 0   2 0 3 0   1 0 4 0   2 1 4 0   1 1 5 0   2 0 5 0
1 0 7 0
1 2 0 0   2 3 0 0   1 2 1 0   2 3 1 0   1 3 2 0   2 2 2 0
1 3 3 0   2 2 3 0   1 2 4 0   2 3 4 0   1 3 5 0   2 2 5 0
1 4 0 0   2 5 0 0   1 4 1 0   2 5 1 0   1 6 0 0   2 4 2 0
1 6 1 0   2 4 3 0   1 5 2 0   2 6 2 0   1 5 3 0   2 6 3 0
1 4 4 0   2 5 4 0   1 6 4 0   2 4 5 0   1 5 5 0   2 6 5 3

//--- vlog.f
c4_pkg.sv
c4_win_check.sv
c4_game.sv
vga_timing.sv
c4_render.sv
connect_4.sv
connect_4_chk.sv
tb_connect_4.sv
